/* dp8_pkg.sv */
package dp8_pkg;

    // Datapath widths
    localparam int DATA_W      = 8;
    localparam int REG_IDX_W   = 3;
    localparam int IRAM_ADDR_W = 5;
    localparam int BANK_W      = IRAM_ADDR_W - REG_IDX_W;
    localparam int OP_W        = 4;

    // APB bus widths and register offsets
    localparam int APB_ADDR_W = 4;
    localparam int APB_DATA_W = 32;

    localparam logic [APB_ADDR_W-1:0] REG_INSTR = 4'h0;
    localparam logic [APB_ADDR_W-1:0] REG_ACC   = 4'h4;
    localparam logic [APB_ADDR_W-1:0] REG_PSW   = 4'h8;

    // PSW bit positions
    localparam int PSW_CY  = 7;
    localparam int PSW_AC  = 6;
    localparam int PSW_RS1 = 4;
    localparam int PSW_RS0 = 3;
    localparam int PSW_OV  = 2;
    localparam int PSW_P   = 0;

    // Instruction word fields
    localparam int INSTR_OP_LSB  = 0;
    localparam int INSTR_SRC_BIT = 4;
    localparam int INSTR_IDX_LSB = 8;
    localparam int INSTR_IMM_LSB = 16;

    // Codes above OP_DEC are reserved
    typedef enum logic [OP_W-1:0] {
        OP_NOP       = 4'h0,
        OP_MOV_A     = 4'h1,
        OP_MOV_R_A   = 4'h2,
        OP_MOV_R_IMM = 4'h3,
        OP_ADD       = 4'h4,
        OP_SUBB      = 4'h5,
        OP_ANL       = 4'h6,
        OP_ORL       = 4'h7,
        OP_XRL       = 4'h8,
        OP_INC       = 4'h9,
        OP_DEC       = 4'hA
    } op_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_READ = 2'd1,
        ST_EXEC = 2'd2,
        ST_WB   = 2'd3
    } state_t;

endpackage

/* apb_ctrl.sv */
module apb_ctrl import dp8_pkg::*; (
    input  logic                  clock,
    input  logic                  rst,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_DATA_W-1:0] pwdata,
    input  logic [DATA_W-1:0]     acc,
    input  logic [DATA_W-1:0]     psw,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    output op_t                   op,
    output logic                  src_reg,
    output logic [REG_IDX_W-1:0]  reg_idx,
    output logic [DATA_W-1:0]     imm,
    output logic                  rd_en,
    output logic                  wr_en,
    output logic                  wb_en,
    output logic                  psw_wr,
    output logic [DATA_W-1:0]     psw_wdata
);

    state_t state;
    state_t state_next;

    logic setup_cycle;
    logic access_cycle;
    logic idle_access;
    logic instr_sel;
    logic acc_sel;
    logic psw_sel;
    logic bad_addr;
    logic bad_op;
    logic start;

    // ------------------------------
    // Transfer decode
    // ------------------------------
    assign setup_cycle  = psel && !penable;
    assign access_cycle = psel && penable;
    assign idle_access  = (state == ST_IDLE) && access_cycle;

    assign instr_sel = (paddr == REG_INSTR);
    assign acc_sel   = (paddr == REG_ACC);
    assign psw_sel   = (paddr == REG_PSW);
    assign bad_addr  = !(instr_sel || acc_sel || psw_sel);
    assign bad_op    = pwdata[INSTR_OP_LSB +: OP_W] > OP_DEC;

    // Instruction is taken in the setup phase so READ lines up with the first access cycle
    assign start = (state == ST_IDLE) && setup_cycle && pwrite && instr_sel && !bad_op;

    // ------------------------------
    // Sequencer
    // ------------------------------
    always_comb begin
        case (state)
            ST_IDLE: state_next = start ? ST_READ : ST_IDLE;
            ST_READ: state_next = ST_EXEC;
            ST_EXEC: state_next = ST_WB;
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state   <= ST_IDLE;
            op      <= OP_NOP;
            src_reg <= 1'b0;
            reg_idx <= '0;
            imm     <= '0;
        end else begin
            state <= state_next;
            if (start) begin
                op      <= op_t'(pwdata[INSTR_OP_LSB +: OP_W]);
                src_reg <= pwdata[INSTR_SRC_BIT];
                reg_idx <= pwdata[INSTR_IDX_LSB +: REG_IDX_W];
                imm     <= pwdata[INSTR_IMM_LSB +: DATA_W];
            end
        end
    end

    // Datapath strobes
    assign rd_en = (state == ST_READ) && src_reg;
    assign wr_en = (state == ST_EXEC) && ((op == OP_MOV_R_A) || (op == OP_MOV_R_IMM));
    assign wb_en = (state == ST_WB);

    // ------------------------------
    // APB response
    // ------------------------------
    assign pready  = idle_access || (state == ST_WB);
    assign pslverr = idle_access && (bad_addr || (pwrite && instr_sel && bad_op));

    always_comb begin
        prdata = '0;
        if (acc_sel) begin
            prdata[DATA_W-1:0] = acc;
        end else if (psw_sel) begin
            prdata[DATA_W-1:0] = psw;
        end
    end

    assign psw_wr    = idle_access && pwrite && psw_sel;
    assign psw_wdata = pwdata[DATA_W-1:0];

endmodule

/* iram_bank.sv */
module iram_bank import dp8_pkg::*; (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 rd_en,
    input  logic                 wr_en,
    input  logic [REG_IDX_W-1:0] reg_idx,
    input  logic [BANK_W-1:0]    bank,
    input  logic [DATA_W-1:0]    wdata,
    input  op_t                  op,
    input  logic [DATA_W-1:0]    imm,
    output logic [DATA_W-1:0]    rdata
);

    logic [DATA_W-1:0]      mem [2**IRAM_ADDR_W];
    logic [IRAM_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]      store_data;

    // Bank base is eight bytes per bank
    assign addr = {bank, reg_idx};

    // MOV Rn,#imm stores the immediate, MOV Rn,A stores ACC
    assign store_data = (op == OP_MOV_R_IMM) ? imm : wdata;

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < 2**IRAM_ADDR_W; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            if (wr_en) begin
                mem[addr] <= store_data;
            end
            if (rd_en) begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

/* alu_core.sv */
module alu_core import dp8_pkg::*; (
    input  logic              clock,
    input  logic              rst,
    input  op_t               op,
    input  logic              src_reg,
    input  logic [DATA_W-1:0] imm,
    input  logic [DATA_W-1:0] ram_data,
    input  logic [DATA_W-1:0] acc,
    input  logic              cy_in,
    output logic [DATA_W-1:0] result,
    output logic              cy_out,
    output logic              ac_out,
    output logic              ov_out,
    output logic              flags_valid
);

    logic [DATA_W-1:0] operand;
    logic [DATA_W-1:0] res_c;
    logic [DATA_W:0]   wide;
    logic [4:0]        nib;
    logic              cy_c;
    logic              ac_c;
    logic              ov_c;

    assign operand = src_reg ? ram_data : imm;

    always_comb begin
        res_c = acc;
        wide  = '0;
        nib   = '0;
        cy_c  = 1'b0;
        ac_c  = 1'b0;
        ov_c  = 1'b0;
        case (op)
            OP_ADD: begin
                wide  = {1'b0, acc} + {1'b0, operand};
                nib   = {1'b0, acc[3:0]} + {1'b0, operand[3:0]};
                res_c = wide[DATA_W-1:0];
                cy_c  = wide[DATA_W];
                ac_c  = nib[4];
                // Same-sign operands giving a result of the other sign
                ov_c  = (acc[DATA_W-1] == operand[DATA_W-1]) &&
                        (res_c[DATA_W-1] != acc[DATA_W-1]);
            end
            OP_SUBB: begin
                // Top bit of the widened difference is the borrow
                wide  = {1'b0, acc} - {1'b0, operand} - {{DATA_W{1'b0}}, cy_in};
                nib   = {1'b0, acc[3:0]} - {1'b0, operand[3:0]} - {4'b0, cy_in};
                res_c = wide[DATA_W-1:0];
                cy_c  = wide[DATA_W];
                ac_c  = nib[4];
                ov_c  = (acc[DATA_W-1] != operand[DATA_W-1]) &&
                        (res_c[DATA_W-1] != acc[DATA_W-1]);
            end
            OP_ANL:  res_c = acc & operand;
            OP_ORL:  res_c = acc | operand;
            OP_XRL:  res_c = acc ^ operand;
            OP_INC:  res_c = acc + DATA_W'(1);
            OP_DEC:  res_c = acc - DATA_W'(1);
            default: res_c = acc;
        endcase
    end

    // Sampled every cycle, the EXEC-cycle value is the one used in WB
    always_ff @(posedge clock) begin
        if (rst) begin
            result      <= '0;
            cy_out      <= 1'b0;
            ac_out      <= 1'b0;
            ov_out      <= 1'b0;
            flags_valid <= 1'b0;
        end else begin
            result      <= res_c;
            cy_out      <= cy_c;
            ac_out      <= ac_c;
            ov_out      <= ov_c;
            flags_valid <= (op == OP_ADD) || (op == OP_SUBB);
        end
    end

endmodule

/* acc_psw.sv */
module acc_psw import dp8_pkg::*; (
    input  logic              clock,
    input  logic              rst,
    input  logic              wb_en,
    input  op_t               op,
    input  logic              src_reg,
    input  logic [DATA_W-1:0] imm,
    input  logic [DATA_W-1:0] ram_data,
    input  logic [DATA_W-1:0] result,
    input  logic              cy_out,
    input  logic              ac_out,
    input  logic              ov_out,
    input  logic              flags_valid,
    input  logic              psw_wr,
    input  logic [DATA_W-1:0] psw_wdata,
    output logic [DATA_W-1:0] acc,
    output logic [DATA_W-1:0] psw,
    output logic [BANK_W-1:0] bank
);

    // Stored PSW bits, P lives outside
    logic [DATA_W-1:1] psw_q;
    logic              alu_op;

    assign alu_op = (op == OP_ADD) || (op == OP_SUBB) || (op == OP_ANL) ||
                    (op == OP_ORL) || (op == OP_XRL) || (op == OP_INC) ||
                    (op == OP_DEC);

    always_ff @(posedge clock) begin
        if (rst) begin
            acc   <= '0;
            psw_q <= '0;
        end else if (psw_wr) begin
            psw_q <= psw_wdata[DATA_W-1:1];
        end else if (wb_en) begin
            if (alu_op) begin
                acc <= result;
            end else if (op == OP_MOV_A) begin
                acc <= src_reg ? ram_data : imm;
            end
            if (flags_valid) begin
                psw_q[PSW_CY] <= cy_out;
                psw_q[PSW_AC] <= ac_out;
                psw_q[PSW_OV] <= ov_out;
            end
        end
    end

    // Parity follows ACC every cycle
    always_comb begin
        psw        = {psw_q, 1'b0};
        psw[PSW_P] = ^acc;
    end

    assign bank = psw_q[PSW_RS1:PSW_RS0];

endmodule

/* dp8_top.sv */
module dp8_top import dp8_pkg::*; (
    input  logic                  clock,
    input  logic                  rst,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_DATA_W-1:0] pwdata,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr
);

    op_t                  op;
    logic                 src_reg;
    logic [REG_IDX_W-1:0] reg_idx;
    logic [DATA_W-1:0]    imm;
    logic                 rd_en;
    logic                 wr_en;
    logic                 wb_en;
    logic                 psw_wr;
    logic [DATA_W-1:0]    psw_wdata;
    logic [DATA_W-1:0]    acc;
    logic [DATA_W-1:0]    psw;
    logic [BANK_W-1:0]    bank;
    logic [DATA_W-1:0]    ram_data;
    logic [DATA_W-1:0]    result;
    logic                 cy_out;
    logic                 ac_out;
    logic                 ov_out;
    logic                 flags_valid;

    // ------------------------------
    // Host interface and sequencer
    // ------------------------------
    apb_ctrl apb_ctrl_inst (
        .clock     (clock),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .acc       (acc),
        .psw       (psw),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .op        (op),
        .src_reg   (src_reg),
        .reg_idx   (reg_idx),
        .imm       (imm),
        .rd_en     (rd_en),
        .wr_en     (wr_en),
        .wb_en     (wb_en),
        .psw_wr    (psw_wr),
        .psw_wdata (psw_wdata)
    );

    // ------------------------------
    // Register banks and ALU side by side
    // ------------------------------
    iram_bank iram_bank_inst (
        .clock   (clock),
        .rst     (rst),
        .rd_en   (rd_en),
        .wr_en   (wr_en),
        .reg_idx (reg_idx),
        .bank    (bank),
        .wdata   (acc),
        .op      (op),
        .imm     (imm),
        .rdata   (ram_data)
    );

    alu_core alu_core_inst (
        .clock       (clock),
        .rst         (rst),
        .op          (op),
        .src_reg     (src_reg),
        .imm         (imm),
        .ram_data    (ram_data),
        .acc         (acc),
        .cy_in       (psw[PSW_CY]),
        .result      (result),
        .cy_out      (cy_out),
        .ac_out      (ac_out),
        .ov_out      (ov_out),
        .flags_valid (flags_valid)
    );

    // SFR write-back
    acc_psw acc_psw_inst (
        .clock       (clock),
        .rst         (rst),
        .wb_en       (wb_en),
        .op          (op),
        .src_reg     (src_reg),
        .imm         (imm),
        .ram_data    (ram_data),
        .result      (result),
        .cy_out      (cy_out),
        .ac_out      (ac_out),
        .ov_out      (ov_out),
        .flags_valid (flags_valid),
        .psw_wr      (psw_wr),
        .psw_wdata   (psw_wdata),
        .acc         (acc),
        .psw         (psw),
        .bank        (bank)
    );

endmodule

/* tb_clock.sv */
module tb_clock (
    output logic clock,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 10;

    // 8 ns period
    initial begin
        clock = 1'b0;
        forever begin
            #4 clock = ~clock;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        rst <= 1'b0;
    end

endmodule

/* tb_dp8.sv */
module tb_dp8 import dp8_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;

    logic                  clock;
    logic                  rst;
    logic [APB_ADDR_W-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    // Reference model of the architectural state
    logic [DATA_W-1:0] acc_m;
    logic [DATA_W-1:1] psw_m;
    logic [DATA_W-1:0] regs_m [2**IRAM_ADDR_W];

    logic [31:0] lfsr;
    int          errors;
    int          tests_run;
    int          tests_failed;

    tb_clock tb_clock_inst (
        .clock (clock),
        .rst   (rst)
    );

    dp8_top dp8_top_inst (
        .clock   (clock),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    // ------------------------------
    // Random bits
    // ------------------------------
    function automatic logic take_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    function automatic logic [DATA_W-1:0] rand_byte();
        logic [DATA_W-1:0] val;
        val = '0;
        for (int i = 0; i < DATA_W; i++) begin
            val = {val[DATA_W-2:0], take_bit()};
        end
        return val;
    endfunction

    function automatic logic [REG_IDX_W-1:0] rand_idx();
        logic [REG_IDX_W-1:0] val;
        val = '0;
        for (int i = 0; i < REG_IDX_W; i++) begin
            val = {val[REG_IDX_W-2:0], take_bit()};
        end
        return val;
    endfunction

    // ------------------------------
    // APB transfers
    // ------------------------------
    task automatic apb_transfer(
        input  logic                  write,
        input  logic [APB_ADDR_W-1:0] addr,
        input  logic [APB_DATA_W-1:0] wdata,
        output logic [APB_DATA_W-1:0] rdata,
        output logic                  err
    );
        @(posedge clock);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clock);
        penable <= 1'b1;
        @(posedge clock);
        while (!pready) begin
            @(posedge clock);
        end
        rdata = prdata;
        err   = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(
        input  logic [APB_ADDR_W-1:0] addr,
        input  logic [APB_DATA_W-1:0] wdata,
        output logic                  err
    );
        logic [APB_DATA_W-1:0] unused_rdata;
        apb_transfer(1'b1, addr, wdata, unused_rdata, err);
    endtask

    task automatic apb_read(
        input  logic [APB_ADDR_W-1:0] addr,
        output logic [APB_DATA_W-1:0] rdata,
        output logic                  err
    );
        apb_transfer(1'b0, addr, '0, rdata, err);
    endtask

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_acc(input logic [DATA_W-1:0] expected, input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t: acc expected 8'h%02h, actual 8'h%02h",
                     $time, expected, actual);
            errors++;
        end
    endtask

    task automatic check_psw(input logic [DATA_W-1:0] expected, input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t: psw expected 8'b%08b, actual 8'b%08b",
                     $time, expected, actual);
            errors++;
        end
    endtask

    task automatic check_err(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error at %0t: pslverr expected %0b, actual %0b",
                     $time, expected, actual);
            errors++;
        end
    endtask

    // ------------------------------
    // Instruction and state helpers
    // ------------------------------
    function automatic logic [APB_DATA_W-1:0] instr_word(
        input logic [OP_W-1:0]      code,
        input logic                 src,
        input logic [REG_IDX_W-1:0] idx,
        input logic [DATA_W-1:0]    imm_val
    );
        logic [APB_DATA_W-1:0] word;
        word = '0;
        word[INSTR_OP_LSB +: OP_W]       = code;
        word[INSTR_SRC_BIT]              = src;
        word[INSTR_IDX_LSB +: REG_IDX_W] = idx;
        word[INSTR_IMM_LSB +: DATA_W]    = imm_val;
        return word;
    endfunction

    task automatic run_instr(
        input logic [OP_W-1:0]      code,
        input logic                 src,
        input logic [REG_IDX_W-1:0] idx,
        input logic [DATA_W-1:0]    imm_val
    );
        logic err;
        apb_write(REG_INSTR, instr_word(code, src, idx, imm_val), err);
        check_err(1'b0, err);
    endtask

    task automatic write_psw(input logic [DATA_W-1:0] value);
        logic err;
        apb_write(REG_PSW, {{(APB_DATA_W-DATA_W){1'b0}}, value}, err);
        check_err(1'b0, err);
        // P is computed, never stored
        psw_m = value[DATA_W-1:1];
    endtask

    task automatic verify_state();
        logic [APB_DATA_W-1:0] data;
        logic                  err;
        apb_read(REG_ACC, data, err);
        check_err(1'b0, err);
        check_acc(acc_m, data[DATA_W-1:0]);
        apb_read(REG_PSW, data, err);
        check_err(1'b0, err);
        check_psw({psw_m, ^acc_m}, data[DATA_W-1:0]);
    endtask

    // Carry out of bit 7, carry out of bit 3, signed overflow
    task automatic model_add(input logic [DATA_W-1:0] b);
        int                sum;
        logic [DATA_W-1:0] res;
        sum = int'(acc_m) + int'(b);
        res = sum[DATA_W-1:0];
        psw_m[PSW_CY] = sum > 255;
        psw_m[PSW_AC] = (int'(acc_m[3:0]) + int'(b[3:0])) > 15;
        psw_m[PSW_OV] = (acc_m[7] == b[7]) && (res[7] != acc_m[7]);
        acc_m = res;
    endtask

    // Borrows show up as negative differences
    task automatic model_subb(input logic [DATA_W-1:0] b);
        int                diff;
        int                nib;
        logic [DATA_W-1:0] res;
        diff = int'(acc_m) - int'(b) - int'(psw_m[PSW_CY]);
        nib  = int'(acc_m[3:0]) - int'(b[3:0]) - int'(psw_m[PSW_CY]);
        res  = diff[DATA_W-1:0];
        psw_m[PSW_CY] = diff < 0;
        psw_m[PSW_AC] = nib < 0;
        psw_m[PSW_OV] = (acc_m[7] != b[7]) && (res[7] != acc_m[7]);
        acc_m = res;
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_mov_imm();
        logic [DATA_W-1:0] value;
        for (int n = 0; n < 8; n++) begin
            value = rand_byte();
            run_instr(OP_MOV_A, 1'b0, '0, value);
            acc_m = value;
            verify_state();
        end
    endtask

    task automatic test_add_subb();
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] psw_val;
        for (int n = 0; n < 8; n++) begin
            a = rand_byte();
            b = rand_byte();
            psw_val = '0;
            psw_val[PSW_CY] = take_bit();
            psw_val[PSW_AC] = take_bit();
            psw_val[PSW_OV] = take_bit();
            write_psw(psw_val);
            run_instr(OP_MOV_A, 1'b0, '0, a);
            acc_m = a;
            if (n % 2 == 0) begin
                run_instr(OP_ADD, 1'b0, '0, b);
                model_add(b);
            end else begin
                run_instr(OP_SUBB, 1'b0, '0, b);
                model_subb(b);
            end
            verify_state();
        end
    endtask

    task automatic test_logic_ops();
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        // CY, AC and OV all set so a stray clear shows up
        write_psw(8'hC4);
        for (int k = 0; k < 5; k++) begin
            a = rand_byte();
            b = rand_byte();
            run_instr(OP_MOV_A, 1'b0, '0, a);
            case (k)
                0: begin
                    run_instr(OP_ANL, 1'b0, '0, b);
                    acc_m = a & b;
                end
                1: begin
                    run_instr(OP_ORL, 1'b0, '0, b);
                    acc_m = a | b;
                end
                2: begin
                    run_instr(OP_XRL, 1'b0, '0, b);
                    acc_m = a ^ b;
                end
                3: begin
                    run_instr(OP_INC, 1'b0, '0, b);
                    acc_m = a + 8'd1;
                end
                default: begin
                    run_instr(OP_DEC, 1'b0, '0, b);
                    acc_m = a - 8'd1;
                end
            endcase
            verify_state();
        end
        // Wrap-around at both ends
        run_instr(OP_MOV_A, 1'b0, '0, 8'hFF);
        run_instr(OP_INC, 1'b0, '0, 8'h00);
        acc_m = 8'h00;
        verify_state();
        run_instr(OP_MOV_A, 1'b0, '0, 8'h00);
        run_instr(OP_DEC, 1'b0, '0, 8'h00);
        acc_m = 8'hFF;
        verify_state();
    endtask

    task automatic test_banks();
        logic [REG_IDX_W-1:0] idx_list [3];
        logic [REG_IDX_W-1:0] shared_idx;
        logic [DATA_W-1:0]    value;
        logic [DATA_W-1:0]    psw_val;
        // Last write of every bank goes to the same register number
        shared_idx = rand_idx();
        for (int bk = 0; bk < 4; bk++) begin
            psw_val = '0;
            psw_val[PSW_RS1:PSW_RS0] = bk[1:0];
            write_psw(psw_val);
            for (int n = 0; n < 3; n++) begin
                idx_list[n] = (n == 2) ? shared_idx : rand_idx();
                value = rand_byte();
                run_instr(OP_MOV_R_IMM, 1'b0, idx_list[n], value);
                regs_m[{bk[1:0], idx_list[n]}] = value;
            end
            for (int n = 0; n < 3; n++) begin
                run_instr(OP_MOV_A, 1'b1, idx_list[n], '0);
                acc_m = regs_m[{bk[1:0], idx_list[n]}];
                verify_state();
            end
        end
        // Second pass, after all other banks were written
        for (int bk = 0; bk < 4; bk++) begin
            psw_val = '0;
            psw_val[PSW_RS1:PSW_RS0] = bk[1:0];
            psw_val[PSW_CY] = take_bit();
            write_psw(psw_val);
            run_instr(OP_MOV_A, 1'b1, shared_idx, '0);
            acc_m = regs_m[{bk[1:0], shared_idx}];
            verify_state();
            value = rand_byte();
            run_instr(OP_MOV_A, 1'b0, '0, value);
            acc_m = value;
            run_instr(OP_ADD, 1'b1, shared_idx, '0);
            model_add(regs_m[{bk[1:0], shared_idx}]);
            verify_state();
        end
    endtask

    task automatic test_mov_r_a();
        logic [REG_IDX_W-1:0] idx;
        logic [DATA_W-1:0]    value;
        logic [DATA_W-1:0]    psw_val;
        for (int n = 0; n < 4; n++) begin
            psw_val = '0;
            psw_val[PSW_RS1:PSW_RS0] = n[1:0];
            write_psw(psw_val);
            idx = rand_idx();
            value = rand_byte();
            run_instr(OP_MOV_A, 1'b0, '0, value);
            run_instr(OP_MOV_R_A, 1'b0, idx, '0);
            regs_m[{n[1:0], idx}] = value;
            run_instr(OP_MOV_A, 1'b0, '0, 8'h00);
            acc_m = 8'h00;
            verify_state();
            run_instr(OP_MOV_A, 1'b1, idx, '0);
            acc_m = value;
            verify_state();
        end
    endtask

    task automatic test_errors();
        logic [APB_DATA_W-1:0] data;
        logic                  err;
        logic [DATA_W-1:0]     value;
        value = rand_byte();
        run_instr(OP_MOV_A, 1'b0, '0, value);
        acc_m = value;
        write_psw(8'hA4);
        apb_write(4'hC, 32'h0000_00FF, err);
        check_err(1'b1, err);
        apb_read(4'hC, data, err);
        check_err(1'b1, err);
        // Reserved opcodes with an immediate that would change ACC
        apb_write(REG_INSTR, instr_word(4'hB, 1'b0, '0, ~value), err);
        check_err(1'b1, err);
        apb_write(REG_INSTR, instr_word(4'hF, 1'b0, '0, ~value), err);
        check_err(1'b1, err);
        verify_state();
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s with %0d errors", name, errors - errors_before);
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int mark;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        lfsr         = 32'h881c7625;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        acc_m        = '0;
        psw_m        = '0;
        foreach (regs_m[i]) begin
            regs_m[i] = '0;
        end

        do begin
            @(posedge clock);
        end while (rst !== 1'b0);

        mark = errors;
        test_mov_imm();
        report_test("mov_imm", mark);
        mark = errors;
        test_add_subb();
        report_test("add_subb", mark);
        mark = errors;
        test_logic_ops();
        report_test("logic_ops", mark);
        mark = errors;
        test_banks();
        report_test("banks", mark);
        mark = errors;
        test_mov_r_a();
        report_test("mov_r_a", mark);
        mark = errors;
        test_errors();
        report_test("errors", mark);

        $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clock);
        $display("Watchdog expired after %0d cycles, the tests did not finish",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("Test failures found");
        $finish;
    end

endmodule

/* sources.f */
dp8_pkg.sv
apb_ctrl.sv
iram_bank.sv
alu_core.sv
acc_psw.sv
dp8_top.sv
tb_clock.sv
tb_dp8.sv

/* Makefile */
.PHONY: build run clean

build:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_dp8 \
		-f sources.f -Mdir obj_dir -o tb_dp8

run: build
	@out=$$(./obj_dir/tb_dp8); \
	echo "$$out"; \
	echo "$$out" | grep -qF "All tests passed!"

clean:
	rm -rf obj_dir
